// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_tb
LINT_TOP  ?= exec_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/exec_pkg.sv ====
package exec_pkg;

  // Operand and result width
  localparam int unsigned WORD_W = 32;

  // Queue entries, also the issuer's credit count after reset
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  // Command numbering follows the instruction codegen
  // Gaps are commands this core does not implement
  typedef enum logic [5:0] {
    CMD_ADD   = 6'd1,
    CMD_ADC   = 6'd2,
    CMD_INC   = 6'd3,
    CMD_SUB   = 6'd4,
    CMD_SBB   = 6'd5,
    CMD_DEC   = 6'd6,
    CMD_CMP   = 6'd7,
    CMD_AND   = 6'd10,
    CMD_TEST  = 6'd11,
    CMD_OR    = 6'd12,
    CMD_XOR   = 6'd13,
    CMD_NOT   = 6'd14,
    CMD_MOV   = 6'd20,
    CMD_MOVZX = 6'd21,
    CMD_MOVSX = 6'd22,
    CMD_STC   = 6'd30,
    CMD_CLC   = 6'd31,
    CMD_STD   = 6'd32,
    CMD_CLD   = 6'd33,
    CMD_LAHF  = 6'd34,
    CMD_SAHF  = 6'd35
  } opcode_e;

  // Core ALU operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // EFLAGS bit positions, x86 layout
  localparam int unsigned EFLAGS_CF = 0;
  localparam int unsigned EFLAGS_PF = 2;
  localparam int unsigned EFLAGS_AF = 4;
  localparam int unsigned EFLAGS_ZF = 6;
  localparam int unsigned EFLAGS_SF = 7;
  localparam int unsigned EFLAGS_DF = 10;
  localparam int unsigned EFLAGS_OF = 11;

  // Reserved bit 1 always reads as one
  localparam logic [WORD_W-1:0] EFLAGS_RESET = 32'h0000_0002;

  // Status vector shared by execute, alu and meta
  localparam int unsigned STAT_W  = 7;
  localparam int unsigned STAT_OF = 0;
  localparam int unsigned STAT_SF = 1;
  localparam int unsigned STAT_ZF = 2;
  localparam int unsigned STAT_PF = 3;
  localparam int unsigned STAT_CF = 4;
  localparam int unsigned STAT_AF = 5;
  localparam int unsigned STAT_DF = 6;

endpackage

// ==== execute/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  exec_pkg::alu_op_e                alu_op,
  input  logic                             use_carry,
  input  logic                             keep_cf,
  input  logic                             clear_cf_of,
  input  logic                             no_flags,
  input  logic [exec_pkg::STAT_W-1:0]      status_in,
  input  logic [exec_pkg::WORD_W-1:0]      opnd0,
  input  logic [exec_pkg::WORD_W-1:0]      opnd1,
  output logic [exec_pkg::STAT_W-1:0]      status_out,
  output logic [exec_pkg::WORD_W-1:0]      result
);

  import exec_pkg::*;

  logic              is_sub;
  logic              carry_in;
  logic [WORD_W-1:0] opnd1_eff;
  logic [WORD_W:0]   sum;
  logic              arith_cf;
  logic              arith_of;
  logic              arith_af;

  // Subtract as a + ~b + 1, borrow is the inverted carry
  assign is_sub    = (alu_op == ALU_SUB);
  assign opnd1_eff = is_sub ? ~opnd1 : opnd1;

  // ADC adds CF, SBB subtracts it
  assign carry_in  = (use_carry & status_in[STAT_CF]) ^ is_sub;

  // Shared 33-bit adder
  assign sum = {1'b0, opnd0} + {1'b0, opnd1_eff} + {{WORD_W{1'b0}}, carry_in};

  assign arith_cf = sum[WORD_W] ^ is_sub;

  // Same-sign inputs with a sign flip on the output
  assign arith_of = (opnd0[WORD_W-1] == opnd1_eff[WORD_W-1]) &&
                    (sum[WORD_W-1] != opnd0[WORD_W-1]);

  // Carry or borrow out of bit 3, original operand on purpose
  assign arith_af = opnd0[4] ^ opnd1[4] ^ sum[4];

  always_comb begin
    case (alu_op)
      ALU_ADD, ALU_SUB: result = sum[WORD_W-1:0];
      ALU_AND:          result = opnd0 & opnd1;
      ALU_OR:           result = opnd0 | opnd1;
      ALU_XOR:          result = opnd0 ^ opnd1;
      default:          result = '0;
    endcase
  end

  always_comb begin
    status_out = status_in;
    if (!no_flags) begin
      status_out[STAT_SF] = result[WORD_W-1];
      status_out[STAT_ZF] = (result == '0);
      // Even parity of the low byte
      status_out[STAT_PF] = ~^result[7:0];
      // Logic ops clear CF, OF and AF together
      status_out[STAT_OF] = clear_cf_of ? 1'b0 : arith_of;
      status_out[STAT_AF] = clear_cf_of ? 1'b0 : arith_af;
      if (keep_cf) begin
        status_out[STAT_CF] = status_in[STAT_CF];
      end else begin
        status_out[STAT_CF] = clear_cf_of ? 1'b0 : arith_cf;
      end
    end
  end

endmodule

// ==== execute/execute.sv ====
`timescale 1ns/1ps

module execute (
  input  exec_pkg::opcode_e                opc,
  input  logic [exec_pkg::WORD_W-1:0]      eflags,
  input  logic [exec_pkg::WORD_W-1:0]      opnd0,
  input  logic [exec_pkg::WORD_W-1:0]      opnd1,
  output logic [exec_pkg::WORD_W-1:0]      eflags_out,
  output logic [exec_pkg::WORD_W-1:0]      result,
  output logic                             result_wr
);

  import exec_pkg::*;

  // Decoded controls
  alu_op_e            alu_op;
  logic               is_alu;
  logic               is_move;
  logic               is_meta;
  logic               use_carry;
  logic               keep_cf;
  logic               clear_cf_of;
  logic               no_flags;
  logic               no_wr;
  logic               src_one;
  logic               src_ones;
  logic               mu_sext;
  logic               mu_zext;
  logic               is_lahf;

  logic [WORD_W-1:0]  alu_opnd1;
  logic [WORD_W-1:0]  alu_result;
  logic [WORD_W-1:0]  mu_result;
  logic [STAT_W-1:0]  status_in;
  logic [STAT_W-1:0]  alu_status;
  logic [STAT_W-1:0]  meta_status;
  logic [STAT_W-1:0]  status_new;
  logic [7:0]         ah_out;

  always_comb begin
    alu_op      = ALU_ADD;
    is_alu      = 1'b0;
    is_move     = 1'b0;
    is_meta     = 1'b0;
    use_carry   = 1'b0;
    keep_cf     = 1'b0;
    clear_cf_of = 1'b0;
    no_flags    = 1'b0;
    no_wr       = 1'b0;
    src_one     = 1'b0;
    src_ones    = 1'b0;
    mu_sext     = 1'b0;
    mu_zext     = 1'b0;
    is_lahf     = 1'b0;
    case (opc)
      CMD_ADD:   is_alu = 1'b1;
      CMD_ADC:   begin is_alu = 1'b1; use_carry = 1'b1; end
      CMD_INC:   begin is_alu = 1'b1; src_one = 1'b1; keep_cf = 1'b1; end
      CMD_SUB:   begin is_alu = 1'b1; alu_op = ALU_SUB; end
      CMD_SBB:   begin is_alu = 1'b1; alu_op = ALU_SUB; use_carry = 1'b1; end
      CMD_DEC:   begin
        is_alu  = 1'b1;
        alu_op  = ALU_SUB;
        src_one = 1'b1;
        keep_cf = 1'b1;
      end
      CMD_CMP:   begin is_alu = 1'b1; alu_op = ALU_SUB; no_wr = 1'b1; end
      CMD_AND:   begin is_alu = 1'b1; alu_op = ALU_AND; clear_cf_of = 1'b1; end
      CMD_TEST:  begin
        is_alu      = 1'b1;
        alu_op      = ALU_AND;
        clear_cf_of = 1'b1;
        no_wr       = 1'b1;
      end
      CMD_OR:    begin is_alu = 1'b1; alu_op = ALU_OR; clear_cf_of = 1'b1; end
      CMD_XOR:   begin is_alu = 1'b1; alu_op = ALU_XOR; clear_cf_of = 1'b1; end
      // NOT is XOR against all ones, flags untouched
      CMD_NOT:   begin is_alu = 1'b1; alu_op = ALU_XOR; src_ones = 1'b1; no_flags = 1'b1; end
      CMD_MOV:   is_move = 1'b1;
      CMD_MOVZX: begin is_move = 1'b1; mu_zext = 1'b1; end
      CMD_MOVSX: begin is_move = 1'b1; mu_sext = 1'b1; end
      CMD_LAHF:  begin is_meta = 1'b1; is_lahf = 1'b1; end
      CMD_STC, CMD_CLC, CMD_STD, CMD_CLD, CMD_SAHF: is_meta = 1'b1;
      default:   ;
    endcase
  end

  // Second ALU operand, constant for INC/DEC and NOT
  assign alu_opnd1 = src_one  ? WORD_W'(1) :
                     src_ones ? '1         :
                                opnd1;

  // Pull the architectural flags into status order
  always_comb begin
    status_in          = '0;
    status_in[STAT_OF] = eflags[EFLAGS_OF];
    status_in[STAT_SF] = eflags[EFLAGS_SF];
    status_in[STAT_ZF] = eflags[EFLAGS_ZF];
    status_in[STAT_PF] = eflags[EFLAGS_PF];
    status_in[STAT_CF] = eflags[EFLAGS_CF];
    status_in[STAT_AF] = eflags[EFLAGS_AF];
    status_in[STAT_DF] = eflags[EFLAGS_DF];
  end

  alu alu_i (
    .alu_op      (alu_op),
    .use_carry   (use_carry),
    .keep_cf     (keep_cf),
    .clear_cf_of (clear_cf_of),
    .no_flags    (no_flags),
    .status_in   (status_in),
    .opnd0       (opnd0),
    .opnd1       (alu_opnd1),
    .status_out  (alu_status),
    .result      (alu_result)
  );

  meta meta_i (
    .opc        (opc),
    .ah_in      (opnd0[15:8]),
    .status_in  (status_in),
    .ah_out     (ah_out),
    .status_out (meta_status)
  );

  // Move path, byte extension only from the low byte
  assign mu_result = mu_zext ? {24'b0, opnd1[7:0]} :
                     mu_sext ? {{24{opnd1[7]}}, opnd1[7:0]} :
                               opnd1;

  always_comb begin
    if (is_alu) begin
      result     = alu_result;
      result_wr  = !no_wr;
      status_new = alu_status;
    end else if (is_move) begin
      result     = mu_result;
      result_wr  = 1'b1;
      status_new = status_in;
    end else if (is_meta) begin
      // LAHF lands in AH, rest of the word passes
      result     = {opnd0[31:16], ah_out, opnd0[7:0]};
      result_wr  = is_lahf;
      status_new = meta_status;
    end else begin
      result     = '0;
      result_wr  = 1'b0;
      status_new = status_in;
    end
  end

  // Merge back, reserved and system bits kept
  always_comb begin
    eflags_out            = eflags;
    eflags_out[EFLAGS_OF] = status_new[STAT_OF];
    eflags_out[EFLAGS_SF] = status_new[STAT_SF];
    eflags_out[EFLAGS_ZF] = status_new[STAT_ZF];
    eflags_out[EFLAGS_PF] = status_new[STAT_PF];
    eflags_out[EFLAGS_CF] = status_new[STAT_CF];
    eflags_out[EFLAGS_AF] = status_new[STAT_AF];
    eflags_out[EFLAGS_DF] = status_new[STAT_DF];
  end

endmodule

// ==== execute/meta.sv ====
`timescale 1ns/1ps

module meta (
  input  exec_pkg::opcode_e                opc,
  input  logic [7:0]                       ah_in,
  input  logic [exec_pkg::STAT_W-1:0]      status_in,
  output logic [7:0]                       ah_out,
  output logic [exec_pkg::STAT_W-1:0]      status_out
);

  import exec_pkg::*;

  // LAHF byte layout: SF ZF 0 AF 0 PF 1 CF
  assign ah_out = {
    status_in[STAT_SF],
    status_in[STAT_ZF],
    1'b0,
    status_in[STAT_AF],
    1'b0,
    status_in[STAT_PF],
    1'b1,
    status_in[STAT_CF]
  };

  always_comb begin
    status_out = status_in;
    case (opc)
      CMD_STC: status_out[STAT_CF] = 1'b1;
      CMD_CLC: status_out[STAT_CF] = 1'b0;
      CMD_STD: status_out[STAT_DF] = 1'b1;
      CMD_CLD: status_out[STAT_DF] = 1'b0;
      CMD_SAHF: begin
        // Reserved AH bits are ignored
        status_out[STAT_SF] = ah_in[7];
        status_out[STAT_ZF] = ah_in[6];
        status_out[STAT_AF] = ah_in[4];
        status_out[STAT_PF] = ah_in[2];
        status_out[STAT_CF] = ah_in[0];
      end
      default: ;
    endcase
  end

endmodule

// ==== rtl/exec_queue.sv ====
`timescale 1ns/1ps

module exec_queue (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             push,
  input  exec_pkg::opcode_e                push_opc,
  input  logic [exec_pkg::WORD_W-1:0]      push_opnd0,
  input  logic [exec_pkg::WORD_W-1:0]      push_opnd1,
  input  logic                             pop,
  output logic                             empty,
  output exec_pkg::opcode_e                head_opc,
  output logic [exec_pkg::WORD_W-1:0]      head_opnd0,
  output logic [exec_pkg::WORD_W-1:0]      head_opnd1
);

  import exec_pkg::*;

  // Entry storage
  opcode_e                opc_mem   [QUEUE_DEPTH];
  logic [WORD_W-1:0]      opnd0_mem [QUEUE_DEPTH];
  logic [WORD_W-1:0]      opnd1_mem [QUEUE_DEPTH];

  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (push) begin
      opc_mem[wr_ptr]   <= push_opc;
      opnd0_mem[wr_ptr] <= push_opnd0;
      opnd1_mem[wr_ptr] <= push_opnd1;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign empty      = (count == '0);

  // Head read is combinational into execute
  assign head_opc   = opc_mem[rd_ptr];
  assign head_opnd0 = opnd0_mem[rd_ptr];
  assign head_opnd1 = opnd1_mem[rd_ptr];

endmodule

// ==== rtl/exec_top.sv ====
`timescale 1ns/1ps

module exec_top (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             in_valid,
  input  exec_pkg::opcode_e                in_opc,
  input  logic [exec_pkg::WORD_W-1:0]      in_opnd0,
  input  logic [exec_pkg::WORD_W-1:0]      in_opnd1,
  input  logic                             hold,
  output logic                             credit_return,
  output logic                             res_valid,
  output logic                             res_wr,
  output logic [exec_pkg::WORD_W-1:0]      res_data,
  output logic [exec_pkg::WORD_W-1:0]      eflags
);

  import exec_pkg::*;

  logic              empty;
  logic              pop;
  opcode_e           head_opc;
  logic [WORD_W-1:0] head_opnd0;
  logic [WORD_W-1:0] head_opnd1;
  logic [WORD_W-1:0] exe_eflags;
  logic [WORD_W-1:0] exe_result;
  logic              exe_wr;

  // Retire one op per cycle unless downstream holds
  assign pop = !empty && !hold;

  exec_queue exec_queue_i (
    .clk        (clk),
    .reset      (reset),
    .push       (in_valid),
    .push_opc   (in_opc),
    .push_opnd0 (in_opnd0),
    .push_opnd1 (in_opnd1),
    .pop        (pop),
    .empty      (empty),
    .head_opc   (head_opc),
    .head_opnd0 (head_opnd0),
    .head_opnd1 (head_opnd1)
  );

  execute execute_i (
    .opc        (head_opc),
    .eflags     (eflags),
    .opnd0      (head_opnd0),
    .opnd1      (head_opnd1),
    .eflags_out (exe_eflags),
    .result     (exe_result),
    .result_wr  (exe_wr)
  );

  // Architectural EFLAGS and result strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      eflags        <= EFLAGS_RESET;
      res_valid     <= 1'b0;
      res_wr        <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      res_valid     <= pop;
      res_wr        <= pop && exe_wr;
      // One credit back per retired op
      credit_return <= pop;
      if (pop) eflags <= exe_eflags;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (pop) res_data <= exe_result;
  end

endmodule

// ==== sim/exec_props.sv ====
`timescale 1ns/1ps

module exec_props (
  input logic                             clk,
  input logic                             reset,
  input logic                             push,
  input logic                             pop,
  input logic                             empty,
  input logic [exec_pkg::QUEUE_CNT_W-1:0] count
);

  import exec_pkg::*;

  // Credit rule keeps the issuer off a full queue
  no_overflow: assert property (@(posedge clk) disable iff (reset)
    !(push && (count == QUEUE_DEPTH))) else $error("push while queue full");

  no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty) else $error("pop while queue empty");

  // Cleared by the reset edge
  empty_after_reset: assert property (@(posedge clk)
    reset |=> empty) else $error("queue not empty after reset");

endmodule

bind exec_queue exec_props exec_props_i (
  .clk   (clk),
  .reset (reset),
  .push  (push),
  .pop   (pop),
  .empty (empty),
  .count (count)
);

// ==== sim/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb;

  import exec_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  // Ops issued across all tests for the watchdog budget
  localparam int NUM_OPS      = 70;

  logic              clk;
  logic              reset;
  logic              in_valid;
  opcode_e           in_opc;
  logic [WORD_W-1:0] in_opnd0;
  logic [WORD_W-1:0] in_opnd1;
  logic              hold;
  logic              credit_return;
  logic              res_valid;
  logic              res_wr;
  logic [WORD_W-1:0] res_data;
  logic [WORD_W-1:0] eflags;

  integer            seed = 32'h2067_1f81;
  int                errors;
  int                test_errors;
  int                checks;
  int                tests;
  int                spent;
  int                returned;
  int                valid_seen;
  // Expected architectural flags
  logic [WORD_W-1:0] model_flags;

  exec_top exec_top_i (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .in_opc        (in_opc),
    .in_opnd0      (in_opnd0),
    .in_opnd1      (in_opnd1),
    .hold          (hold),
    .credit_return (credit_return),
    .res_valid     (res_valid),
    .res_wr        (res_wr),
    .res_data      (res_data),
    .eflags        (eflags)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Counted mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (credit_return === 1'b1) returned <= returned + 1;
    if (res_valid === 1'b1) valid_seen <= valid_seen + 1;
  end

  // Reference model of the result and flag rules
  function automatic void model_op(input opcode_e opc, input logic [WORD_W-1:0] a,
                                   input logic [WORD_W-1:0] b, inout logic [WORD_W-1:0] fl,
                                   output logic [WORD_W-1:0] res, output logic wr);
    logic [WORD_W:0]   full;
    logic [WORD_W-1:0] y;
    logic              cin;
    logic              cf;
    logic              af;
    logic              of;
    logic              upd;
    res = '0;
    wr  = 1'b1;
    cf  = 1'b0;
    af  = 1'b0;
    of  = 1'b0;
    upd = 1'b1;
    // INC and DEC use a constant one
    y   = (opc == CMD_INC || opc == CMD_DEC) ? 32'd1 : b;
    case (opc)
      CMD_ADD, CMD_ADC, CMD_INC: begin
        cin  = (opc == CMD_ADC) && fl[EFLAGS_CF];
        full = {1'b0, a} + {1'b0, y} + 33'(cin);
        res  = full[WORD_W-1:0];
        cf   = full[WORD_W];
        af   = ({1'b0, a[3:0]} + {1'b0, y[3:0]} + 5'(cin)) > 5'd15;
        of   = (a[31] == y[31]) && (res[31] != a[31]);
      end
      CMD_SUB, CMD_SBB, CMD_DEC, CMD_CMP: begin
        cin = (opc == CMD_SBB) && fl[EFLAGS_CF];
        res = a - y - 32'(cin);
        // Borrow when the subtrahend exceeds the minuend
        cf  = {1'b0, a} < ({1'b0, y} + 33'(cin));
        af  = {1'b0, a[3:0]} < ({1'b0, y[3:0]} + 5'(cin));
        of  = (a[31] != y[31]) && (res[31] != a[31]);
        wr  = (opc != CMD_CMP);
      end
      CMD_AND, CMD_TEST: begin
        res = a & b;
        wr  = (opc != CMD_TEST);
      end
      CMD_OR:    res = a | b;
      CMD_XOR:   res = a ^ b;
      default:   upd = 1'b0;
    endcase
    case (opc)
      CMD_NOT:   res = ~a;
      CMD_MOV:   res = b;
      CMD_MOVZX: res = {24'h0, b[7:0]};
      CMD_MOVSX: res = {{24{b[7]}}, b[7:0]};
      CMD_STC:   fl[EFLAGS_CF] = 1'b1;
      CMD_CLC:   fl[EFLAGS_CF] = 1'b0;
      CMD_STD:   fl[EFLAGS_DF] = 1'b1;
      CMD_CLD:   fl[EFLAGS_DF] = 1'b0;
      CMD_LAHF:  res = {a[31:16], fl[EFLAGS_SF], fl[EFLAGS_ZF], 1'b0, fl[EFLAGS_AF],
                        1'b0, fl[EFLAGS_PF], 1'b1, fl[EFLAGS_CF], a[7:0]};
      CMD_SAHF:  begin
        fl[EFLAGS_SF] = a[15];
        fl[EFLAGS_ZF] = a[14];
        fl[EFLAGS_AF] = a[12];
        fl[EFLAGS_PF] = a[10];
        fl[EFLAGS_CF] = a[8];
      end
      default:   ;
    endcase
    if (upd) begin
      fl[EFLAGS_SF] = res[31];
      fl[EFLAGS_ZF] = (res == '0);
      fl[EFLAGS_PF] = ~^res[7:0];
      fl[EFLAGS_OF] = of;
      fl[EFLAGS_AF] = af;
      if (opc != CMD_INC && opc != CMD_DEC) fl[EFLAGS_CF] = cf;
    end
    // Flag-only ops and unknown codes write nothing
    if (opc inside {CMD_STC, CMD_CLC, CMD_STD, CMD_CLD, CMD_SAHF}) wr = 1'b0;
    if (!(opc inside {CMD_ADD, CMD_ADC, CMD_INC, CMD_SUB, CMD_SBB, CMD_DEC, CMD_CMP,
                      CMD_AND, CMD_TEST, CMD_OR, CMD_XOR, CMD_NOT, CMD_MOV, CMD_MOVZX,
                      CMD_MOVSX, CMD_STC, CMD_CLC, CMD_STD, CMD_CLD, CMD_LAHF, CMD_SAHF}))
      wr = 1'b0;
  endfunction

  function automatic int credits_left();
    return int'(QUEUE_DEPTH) - spent + returned;
  endfunction

  task automatic compare(input string name, input logic [WORD_W-1:0] exp,
                         input logic [WORD_W-1:0] act);
    checks++;
    if (exp !== act) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic issue_op(input opcode_e opc, input logic [WORD_W-1:0] a,
                          input logic [WORD_W-1:0] b);
    @(posedge clk);
    // Stall until a credit comes back
    while (credits_left() == 0) begin
      @(posedge clk);
    end
    in_valid <= 1'b1;
    in_opc   <= opc;
    in_opnd0 <= a;
    in_opnd1 <= b;
    spent++;
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic expect_result(input string name, input logic exp_wr,
                               input logic [WORD_W-1:0] exp_data,
                               input logic [WORD_W-1:0] exp_flags);
    do begin
      @(negedge clk);
    end while (res_valid !== 1'b1);
    compare({name, " res_wr"}, 32'(exp_wr), 32'(res_wr));
    // Payload only matters when written
    if (exp_wr) compare({name, " res_data"}, exp_data, res_data);
    compare({name, " eflags"}, exp_flags, eflags);
  endtask

  task automatic run_op(input string name, input opcode_e opc, input logic [WORD_W-1:0] a,
                        input logic [WORD_W-1:0] b);
    logic [WORD_W-1:0] res;
    logic              wr;
    model_op(opc, a, b, model_flags, res, wr);
    issue_op(opc, a, b);
    expect_result(name, wr, res, model_flags);
  endtask

  task automatic finish_test(input string name);
    $display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
    tests++;
    test_errors = 0;
  endtask

  task automatic reset_state_test();
    @(negedge clk);
    compare("reset eflags", EFLAGS_RESET, eflags);
    compare("reset res_valid", 32'h0, 32'(res_valid));
    compare("reset credit_return", 32'h0, 32'(credit_return));
    compare("reset credits", QUEUE_DEPTH, credits_left());
    for (int i = 0; i < QUEUE_DEPTH; i++) run_op("reset mov", CMD_MOV, 32'h0, 32'(i));
    // Every retired op hands its credit back
    @(negedge clk);
    compare("reset credits back", QUEUE_DEPTH, credits_left());
    finish_test("reset_state");
  endtask

  task automatic arith_test();
    opcode_e ops [7] = '{CMD_ADD, CMD_ADC, CMD_SUB, CMD_SBB, CMD_INC, CMD_DEC, CMD_CMP};
    run_op("add overflow", CMD_ADD, 32'h7fff_ffff, 32'h1);
    run_op("sub borrow", CMD_SUB, 32'h0, 32'h1);
    // CF from the borrow above must survive
    run_op("inc keep cf", CMD_INC, 32'hffff_ffff, $random(seed));
    run_op("add nibble", CMD_ADD, 32'h0000_000f, 32'h1);
    run_op("dec zero", CMD_DEC, 32'h0, 32'h0);
    for (int i = 0; i < 3; i++) begin
      foreach (ops[j]) run_op($sformatf("%s rand", ops[j].name()), ops[j],
                              $random(seed), $random(seed));
    end
    finish_test("arithmetic");
  endtask

  task automatic logic_test();
    opcode_e ops [5] = '{CMD_AND, CMD_OR, CMD_XOR, CMD_TEST, CMD_NOT};
    for (int i = 0; i < 2; i++) begin
      foreach (ops[j]) begin
        // Sets CF, OF and AF before every logic op
        run_op("logic setup", CMD_SUB, 32'h7fff_fff0, 32'h8000_0001);
        run_op($sformatf("%s rand", ops[j].name()), ops[j], $random(seed), $random(seed));
      end
    end
    finish_test("logic");
  endtask

  task automatic move_test();
    logic [7:0]        bytes [2] = '{8'h7f, 8'h80};
    logic [WORD_W-1:0] src;
    foreach (bytes[i]) begin
      src = $random(seed);
      src[7:0] = bytes[i];
      run_op("mov", CMD_MOV, $random(seed), src);
      run_op("movzx", CMD_MOVZX, $random(seed), src);
      run_op("movsx", CMD_MOVSX, $random(seed), src);
    end
    finish_test("moves");
  endtask

  task automatic flag_test();
    run_op("stc", CMD_STC, $random(seed), $random(seed));
    run_op("clc", CMD_CLC, $random(seed), $random(seed));
    run_op("std", CMD_STD, $random(seed), $random(seed));
    run_op("cld", CMD_CLD, $random(seed), $random(seed));
    run_op("stc again", CMD_STC, $random(seed), $random(seed));
    run_op("lahf", CMD_LAHF, $random(seed), $random(seed));
    run_op("sahf", CMD_SAHF, $random(seed), $random(seed));
    run_op("lahf after sahf", CMD_LAHF, $random(seed), $random(seed));
    // Code 63 is not a supported command
    run_op("unknown", opcode_e'(6'd63), $random(seed), $random(seed));
    finish_test("flag_unit");
  endtask

  task automatic hold_test();
    opcode_e           ops [QUEUE_DEPTH] = '{CMD_ADD, CMD_XOR, CMD_CMP, CMD_MOVSX};
    logic [WORD_W-1:0] exp_res [QUEUE_DEPTH];
    logic              exp_wr [QUEUE_DEPTH];
    logic [WORD_W-1:0] exp_fl [QUEUE_DEPTH];
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    int                base_valid;
    int                base_ret;
    @(posedge clk);
    hold <= 1'b1;
    base_valid = valid_seen;
    base_ret   = returned;
    foreach (ops[i]) begin
      a = $random(seed);
      b = $random(seed);
      model_op(ops[i], a, b, model_flags, exp_res[i], exp_wr[i]);
      exp_fl[i] = model_flags;
      issue_op(ops[i], a, b);
    end
    repeat (4) @(posedge clk);
    compare("hold res_valid count", base_valid, valid_seen);
    compare("hold credit count", base_ret, returned);
    compare("hold credits left", 32'h0, credits_left());
    hold <= 1'b0;
    // Results drain in issue order
    foreach (ops[i]) expect_result($sformatf("hold op %0d", i), exp_wr[i], exp_res[i], exp_fl[i]);
    @(negedge clk);
    compare("hold credits back", QUEUE_DEPTH, returned - base_ret);
    run_op("after hold", CMD_ADD, $random(seed), $random(seed));
    finish_test("back_pressure");
  endtask

  initial begin
    in_valid    <= 1'b0;
    in_opc      <= CMD_ADD;
    in_opnd0    <= '0;
    in_opnd1    <= '0;
    hold        <= 1'b0;
    reset       <= 1'b1;
    model_flags = EFLAGS_RESET;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    reset_state_test();
    arith_test();
    logic_test();
    move_test();
    flag_test();
    hold_test();
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Twenty cycles per op plus reset
  initial begin
    #((NUM_OPS * 20 + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: the tests did not finish within the cycle budget");
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== sources.f ====
common/exec_pkg.sv
execute/alu.sv
execute/meta.sv
execute/execute.sv
rtl/exec_queue.sv
rtl/exec_top.sv
sim/exec_props.sv
sim/exec_tb.sv
